/* design/softmax_macros.svh */
`ifndef SOFTMAX_MACROS_SVH
`define SOFTMAX_MACROS_SVH

// vector geometry
`define SM_VEC_LEN  8
`define SM_IDX_W    3

// signed Q4.4 input
`define SM_IN_W     8
`define SM_IN_FRAC  4

// unsigned Q12.8 exponential, sum grows by the index width
`define SM_EXP_W    20
`define SM_EXP_FRAC 8
`define SM_SUM_W    23

// unsigned Q1.7 probability
`define SM_OUT_W    8
`define SM_OUT_FRAC 7

`endif

/* design/softmax_pkg.sv */
`include "softmax_macros.svh"

package softmax_pkg;

  typedef logic [`SM_IN_W-1:0]  in_t;    // raw Q4.4 code
  typedef logic [`SM_EXP_W-1:0] exp_t;   // Q12.8 exponential
  typedef logic [`SM_SUM_W-1:0] sum_t;   // vector total
  typedef logic [`SM_OUT_W-1:0] prob_t;  // Q1.7 probability
  typedef logic [`SM_IDX_W-1:0] idx_t;   // element position

  // LOAD takes inputs, FLUSH finishes the last write, DRAIN emits
  typedef enum logic [1:0] {
    LOAD,
    FLUSH,
    DRAIN
  } softmax_state_e;

endpackage

/* design/exp_lut.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module exp_lut (
  input  logic              clk,
  input  logic              lut_en,
  input  softmax_pkg::in_t  in_data,
  output softmax_pkg::exp_t exp_q
);
  import softmax_pkg::*;

  localparam int  LUT_DEPTH = 2 ** `SM_IN_W;
  localparam real IN_SCALE  = 2.0 ** `SM_IN_FRAC;
  localparam real EXP_SCALE = 2.0 ** `SM_EXP_FRAC;
  localparam real EXP_MAX   = (2.0 ** `SM_EXP_W) - 1.0;

  exp_t lut [LUT_DEPTH];

  // table indexed by the raw code, entries are exp(x) in Q12.8
  initial begin
    real x;
    real scaled;
    for (int k = 0; k < LUT_DEPTH; k++) begin
      x = $itor($signed(in_t'(k))) / IN_SCALE;  // code back to signed value
      scaled = $floor($exp(x) * EXP_SCALE + 0.5);
      if (scaled < 1.0) begin
        scaled = 1.0;  // never zero, so the sum stays nonzero
      end else if (scaled > EXP_MAX) begin
        scaled = EXP_MAX;
      end
      lut[k] = exp_t'($rtoi(scaled));
    end
  end

  always_ff @(posedge clk) begin
    if (lut_en) begin
      exp_q <= lut[in_data];  // one cycle read latency
    end
  end

endmodule

/* design/exp_buffer.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module exp_buffer (
  input  logic              clk,
  input  logic              wr_en,
  input  softmax_pkg::idx_t wr_idx,
  input  softmax_pkg::exp_t wr_exp,
  input  softmax_pkg::idx_t rd_idx,
  output softmax_pkg::exp_t rd_exp
);
  import softmax_pkg::*;

  localparam idx_t IDX_LAST = idx_t'(`SM_VEC_LEN - 1);

  exp_t mem [`SM_VEC_LEN];  // one vector of exponentials

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_exp;
    end
  end

  // read is combinational so the divider sees it in the load cycle
  assign rd_exp = mem[rd_idx];

  // back-to-back writes step through the slots and never run past the end
  a_wr_idx_range: assert property (
    @(posedge clk) ($past(wr_en) && wr_en) |->
      ($past(wr_idx) != IDX_LAST) && (wr_idx == $past(wr_idx) + idx_t'(1))
  ) else $error("exp_buffer write index out of range");

endmodule

/* design/exp_accumulator.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module exp_accumulator (
  input  logic              clk,
  input  logic              rst,
  input  logic              acc_clear,
  input  logic              acc_add,
  input  softmax_pkg::exp_t add_exp,
  output softmax_pkg::sum_t sum
);
  import softmax_pkg::*;

  localparam int ACC_W = `SM_SUM_W + 1;  // one spare bit to catch a carry

  logic [ACC_W-1:0] sum_next;

  assign sum_next = {1'b0, sum} + ACC_W'(add_exp);

  // total stays put through FLUSH and DRAIN until the clear
  always_ff @(posedge clk) begin
    if (rst || acc_clear) begin
      sum <= '0;
    end else if (acc_add) begin
      sum <= sum_next[`SM_SUM_W-1:0];
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    acc_add |-> !sum_next[`SM_SUM_W]
  ) else $error("exponential sum overflow");

endmodule

/* design/norm_divider.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module norm_divider (
  input  logic               clk,
  input  logic               rst,
  input  logic               out_load,
  input  softmax_pkg::exp_t  rd_exp,
  input  softmax_pkg::sum_t  sum,
  output softmax_pkg::prob_t out_data
);
  import softmax_pkg::*;

  localparam int SHIFT = `SM_OUT_FRAC + 1;  // output fraction plus a round bit
  localparam int DIV_W = `SM_EXP_W + SHIFT;
  localparam int Q_W   = `SM_OUT_W + 1;

  logic [DIV_W-1:0] dividend;
  logic [Q_W-1:0]   q;
  prob_t            rounded;

  assign dividend = {rd_exp, {SHIFT{1'b0}}};

  // e never exceeds the sum, so the quotient fits in Q_W bits
  assign q = Q_W'(dividend / DIV_W'(sum));

  // round half up on the extra bit
  assign rounded = q[`SM_OUT_W:1] + prob_t'(q[0]);

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= rounded;
    end
  end

  a_sum_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    out_load |-> (sum != '0)
  ) else $error("divide by zero sum");

endmodule

/* design/softmax_ctrl.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module softmax_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              out_ready,
  output logic              out_valid,
  output logic              out_last,
  output logic              lut_en,
  output logic              wr_en,
  output softmax_pkg::idx_t wr_idx,
  output logic              acc_add,
  output logic              acc_clear,
  output softmax_pkg::idx_t rd_idx,
  output logic              out_load
);
  import softmax_pkg::*;

  localparam idx_t IDX_LAST = idx_t'(`SM_VEC_LEN - 1);

  softmax_state_e state;
  idx_t           in_cnt;     // next input position
  idx_t           drain_idx;  // element held in the output register
  logic           accept;
  logic           out_xfer;
  logic           last_xfer;

  assign in_ready  = (state == LOAD);
  assign accept    = in_valid && in_ready;
  assign lut_en    = accept;
  assign acc_add   = wr_en;  // sum and buffer take the same table word
  assign out_xfer  = out_valid && out_ready;
  assign out_last  = out_valid && (drain_idx == IDX_LAST);
  assign last_xfer = out_xfer && out_last;
  assign acc_clear = last_xfer;

  // reload when empty or when the held word leaves, but not past the end
  assign out_load = (state == DRAIN) && (!out_valid || (out_ready && !out_last));
  assign rd_idx   = out_valid ? drain_idx + idx_t'(1) : drain_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= LOAD;
      in_cnt    <= '0;
      wr_en     <= 1'b0;
      drain_idx <= '0;
      out_valid <= 1'b0;
    end else begin
      wr_en <= accept;  // write lands one cycle after the table read
      case (state)
        LOAD: begin
          if (accept) begin
            if (in_cnt == IDX_LAST) begin
              in_cnt <= '0;
              state  <= FLUSH;
            end else begin
              in_cnt <= in_cnt + idx_t'(1);
            end
          end
        end
        FLUSH: begin
          state <= DRAIN;  // last exponential written this cycle
        end
        DRAIN: begin
          if (out_load) begin
            out_valid <= 1'b1;
            if (out_valid) begin
              drain_idx <= drain_idx + idx_t'(1);
            end
          end
          if (last_xfer) begin
            out_valid <= 1'b0;
            drain_idx <= '0;
            state     <= LOAD;
          end
        end
        default: begin
          state <= LOAD;
        end
      endcase
    end
  end

  // write index follows the accept by one cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_idx <= in_cnt;
    end
  end

  a_accept_in_load: assert property (
    @(posedge clk) disable iff (rst)
    lut_en |-> !out_valid && (drain_idx == '0)
  ) else $error("input accepted outside LOAD");

  a_drain_bound: assert property (
    @(posedge clk) disable iff (rst)
    out_last |=> !out_valid || (drain_idx == IDX_LAST)
  ) else $error("drain index moved past the last element");

endmodule

/* design/softmax_top.sv */
`timescale 1ns/100ps

module softmax_top (
  input  logic               clk,
  input  logic               rst,
  input  softmax_pkg::in_t   in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output softmax_pkg::prob_t out_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logic               out_last
);
  import softmax_pkg::*;

  logic lut_en;
  logic wr_en;
  logic acc_add;
  logic acc_clear;
  logic out_load;
  idx_t wr_idx;
  idx_t rd_idx;
  exp_t exp_q;  // registered table word, feeds buffer and sum
  exp_t rd_exp;
  sum_t sum;

  softmax_ctrl ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_last  (out_last),
    .lut_en    (lut_en),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .acc_add   (acc_add),
    .acc_clear (acc_clear),
    .rd_idx    (rd_idx),
    .out_load  (out_load)
  );

  exp_lut lut0 (
    .clk     (clk),
    .lut_en  (lut_en),
    .in_data (in_data),
    .exp_q   (exp_q)
  );

  exp_buffer buf0 (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_idx (wr_idx),
    .wr_exp (exp_q),
    .rd_idx (rd_idx),
    .rd_exp (rd_exp)
  );

  exp_accumulator acc0 (
    .clk       (clk),
    .rst       (rst),
    .acc_clear (acc_clear),
    .acc_add   (acc_add),
    .add_exp   (exp_q),
    .sum       (sum)
  );

  norm_divider div0 (
    .clk      (clk),
    .rst      (rst),
    .out_load (out_load),
    .rd_exp   (rd_exp),
    .sum      (sum),
    .out_data (out_data)
  );

endmodule

/* test/tb_softmax_model.svh */
`ifndef TB_SOFTMAX_MODEL_SVH
`define TB_SOFTMAX_MODEL_SVH

localparam int NUM_TESTS = 8;
localparam int VEC_LEN   = `SM_VEC_LEN;

// one row per vector with name, eight Q4.4 codes, gap mode and stall mode
string test_name [NUM_TESTS] = '{"all_zero", "mixed_a", "extremes", "all_min",
                                 "all_max", "ramp", "mixed_b", "back_to_back"};
in_t test_codes [NUM_TESTS][VEC_LEN] = '{
  '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
  '{8'h10, 8'hF0, 8'h20, 8'hE0, 8'h00, 8'h08, 8'hF8, 8'h30},
  '{8'h7F, 8'h80, 8'h00, 8'h7F, 8'h80, 8'h10, 8'hF0, 8'h40},
  '{8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80},
  '{8'h7F, 8'h7F, 8'h7F, 8'h7F, 8'h7F, 8'h7F, 8'h7F, 8'h7F},
  '{8'hC0, 8'hD0, 8'hE0, 8'hF0, 8'h00, 8'h10, 8'h20, 8'h30},
  '{8'h05, 8'hFB, 8'h3C, 8'hC4, 8'h19, 8'hE7, 8'h7F, 8'h80},
  '{8'h30, 8'h30, 8'h00, 8'h00, 8'hE0, 8'hE0, 8'h10, 8'hF0}
};
bit test_gaps  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
bit test_stall [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
int exp_prob   [NUM_TESTS][VEC_LEN];  // filled before the run

// exp(x) scaled by 256, nearest integer, kept within 1 .. 2^20-1
function automatic int exp_model(in_t code);
  real x;
  int  v;
  x = $itor($signed(code)) / 16.0;
  v = $rtoi($exp(x) * 256.0 + 0.5);
  if (v < 1) begin
    v = 1;
  end else if (v > 1048575) begin
    v = 1048575;
  end
  return v;
endfunction

function automatic int prob_model(int e, int s);
  longint q;
  q = (longint'(e) * 256) / s;  // Q1.7 plus one round bit
  return int'((q >> 1) + (q & 1)) & 255;
endfunction

task automatic build_expected();
  int sum;
  for (int t = 0; t < NUM_TESTS; t++) begin
    sum = 0;
    for (int i = 0; i < VEC_LEN; i++) begin
      sum += exp_model(test_codes[t][i]);
    end
    for (int i = 0; i < VEC_LEN; i++) begin
      exp_prob[t][i] = prob_model(exp_model(test_codes[t][i]), sum);
    end
  end
endtask

`endif

/* test/tb_softmax.sv */
`timescale 1ns/100ps
`include "softmax_macros.svh"

module tb_softmax;
  import softmax_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;

  logic  clk;
  logic  rst;
  in_t   in_data;
  logic  in_valid;
  logic  in_ready;
  prob_t out_data;
  logic  out_valid;
  logic  out_ready;
  logic  out_last;

  `include "tb_softmax_model.svh"

  softmax_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic check_value(string name, int expected, int actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %0d actual %0d", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // all vectors back to back, holding in_valid through stalls
  task automatic drive_inputs();
    int gap;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        gap = test_gaps[t] ? $urandom_range(0, 3) : 0;
        repeat (gap) begin
          @(negedge clk);
          in_valid = 1'b0;
        end
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = test_codes[t][i];
        do begin
          @(posedge clk);
        end while (!in_ready);  // wait for the accept edge
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic collect_outputs();
    string name;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        do begin
          @(negedge clk);
          out_ready = test_stall[t] ? ($urandom_range(0, 3) != 0) : 1'b1;
          @(posedge clk);
        end while (!(out_valid && out_ready));
        name = $sformatf("%s[%0d]", test_name[t], i);
        check_value({name, " data"}, exp_prob[t][i], int'(out_data));
        check_value({name, " last"}, (i == VEC_LEN - 1) ? 1 : 0, int'(out_last));
      end
    end
  endtask

  // in_ready low while a vector drains, out_valid two cycles after the last accept
  initial begin
    int accepts;
    int cycle;
    int last_accept;
    bit busy;
    bit valid_seen;
    accepts     = 0;
    cycle       = 0;
    last_accept = 0;
    busy        = 1'b0;
    valid_seen  = 1'b0;
    forever begin
      @(posedge clk);
      cycle++;
      if (!rst) begin
        if (busy) begin
          check_value("in_ready hold", 0, int'(in_ready));
        end
        if (out_valid && !valid_seen) begin
          check_value("out_valid delay", 2, cycle - 1 - last_accept);  // rose on prior edge
        end
        valid_seen = out_valid;
        if (in_valid && in_ready) begin
          accepts++;
          if (accepts == VEC_LEN) begin
            accepts     = 0;
            busy        = 1'b1;
            last_accept = cycle;
          end
        end
        if (out_valid && out_ready && out_last) begin
          busy = 1'b0;
        end
      end
    end
  end

  initial begin
    #((NUM_TESTS * VEC_LEN * 40 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the output stream did not complete in time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(96));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    build_expected();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      drive_inputs();
      collect_outputs();
    join
    $display("TEST OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
+incdir+test
design/softmax_pkg.sv
design/exp_lut.sv
design/exp_buffer.sv
design/exp_accumulator.sv
design/norm_divider.sv
design/softmax_ctrl.sv
design/softmax_top.sv
test/tb_softmax.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_softmax
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST OK
SIM       = ./$(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
